// ==== design/backup_sequencer.sv ====
// Backup RAM load/save sequencer for the SD block interface, with autosave
`timescale 1ns/1ns
`default_nettype none
`include "gb_loader_consts.svh"

module backup_sequencer import gb_loader_pkg::*; (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  dl_kind_t              dl_kind,
	input  wire                   dl_start,
	input  wire                   dl_end,
	input  wire                   img_mounted,
	input  wire                   img_readonly,
	input  wire                   cart_has_save,
	input  wire                   rtc_inuse,
	input  wire [`GBL_MASK_W-1:0] ram_mask,
	input  wire                   bk_load,
	input  wire                   bk_save,
	input  wire                   autosave,
	input  wire                   osd_open,
	input  wire                   cram_wr,
	input  wire                   sd_ack,
	input  wire                   sd_buff_wr,
	output logic [`GBL_LBA_W-1:0] sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	output logic                  bk_wr,
	output logic                  bk_busy,
	output logic                  bk_loading,
	output logic                  sav_pending,
	output logic                  sav_supported
);

	logic                  bk_ena;
	logic                  new_load;
	logic                  cart_active;
	logic                  load_req;
	logic                  save_req;
	logic                  load_q;
	logic                  save_q;
	logic                  ack_q;
	logic                  load_rise;
	logic                  save_rise;
	logic                  start_xfer;
	logic                  ack_fall;
	logic [`GBL_LBA_W-1:0] mask_lba;
	logic [`GBL_LBA_W-1:0] last_lba;

	//////////////////////////////
	// Requests and block range
	//////////////////////////////

	assign sav_supported = cart_has_save && bk_ena;
	assign load_req      = bk_load || new_load;
	assign save_req      = bk_save || (sav_pending && osd_open && autosave);
	assign load_rise     = load_req && !load_q;
	assign save_rise     = save_req && !save_q;
	assign start_xfer    = !bk_busy && bk_ena && (load_rise || save_rise);
	assign ack_fall      = ack_q && !sd_ack;

	// RTC carts carry one extra block after the RAM image
	assign mask_lba = {{(`GBL_LBA_W-`GBL_MASK_W){1'b0}}, ram_mask};
	assign last_lba = mask_lba + {{(`GBL_LBA_W-1){1'b0}}, rtc_inuse};

	// Only RAM blocks reach cartridge RAM, the clock block is skipped
	assign bk_wr = sd_buff_wr && sd_ack && (sd_lba <= mask_lba);

	// Flags tied to the cartridge download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena      <= 1'b0;
			new_load    <= 1'b0;
			cart_active <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			if (dl_start)
				cart_active <= (dl_kind == DL_CART);
			if (dl_start && dl_kind == DL_CART)
				bk_ena <= 1'b0;
			// The save image is mounted while the cart is still loading
			if (dl_kind == DL_CART && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (dl_end && cart_active && sav_supported)
				new_load <= 1'b1;
			else if (bk_busy)
				new_load <= 1'b0;

			if (start_xfer)
				sav_pending <= 1'b0;
			else if (cram_wr && !osd_open && sav_supported)
				sav_pending <= 1'b1;
		end
	end

	//////////////////////////////
	// Block sequencer
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			load_q <= load_req;
			save_q <= save_req;
			ack_q  <= sd_ack;

			// Drop the request once the SD side has taken it
			if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (start_xfer) begin
				bk_busy    <= 1'b1;
				bk_loading <= load_rise;
				sd_lba     <= '0;
				sd_rd      <= load_rise;
				sd_wr      <= !load_rise;
			end else if (bk_busy && ack_fall) begin
				if (sd_lba >= last_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= !bk_loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/boot_checksum.sv ====
// Custom boot ROM flags, colour boot ROM byte sum and boot feature availability
`timescale 1ns/1ns
`default_nettype none
`include "gb_loader_consts.svh"

module boot_checksum import gb_loader_pkg::*; (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   is_gbc,
	input  dl_kind_t              dl_kind,
	input  wire                   dl_start,
	input  wire                   wr_q,
	input  wire [`GBL_DATA_W-1:0] dout_q,
	output logic                  fastboot_available,
	output logic                  boot_gba_available,
	output logic                  real_cgb_boot
);

	logic                    custom_cgb;
	logic                    custom_dmg;
	logic [`GBL_CKSUM_W-1:0] checksum;
	logic [`GBL_CKSUM_W-1:0] byte_hi;
	logic [`GBL_CKSUM_W-1:0] byte_lo;
	logic [`GBL_CKSUM_W-1:0] word_sum;
	logic                    cgb_write;

	// Both bytes of a word enter the sum together
	assign byte_hi   = {{(`GBL_CKSUM_W-8){1'b0}}, dout_q[15:8]};
	assign byte_lo   = {{(`GBL_CKSUM_W-8){1'b0}}, dout_q[7:0]};
	assign word_sum  = byte_hi + byte_lo;
	assign cgb_write = wr_q && (dl_kind == DL_CGB_BOOT);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_cgb <= 1'b0;
			custom_dmg <= 1'b0;
			checksum   <= '0;
		end else begin
			if (dl_start && dl_kind == DL_CGB_BOOT) begin
				custom_cgb <= 1'b1;
				// A word arriving with the start pulse opens the new sum
				checksum   <= cgb_write ? word_sum : '0;
			end else if (cgb_write) begin
				checksum   <= checksum + word_sum;
			end
			if (dl_start && dl_kind == DL_DMG_BOOT)
				custom_dmg <= 1'b1;
		end
	end

	//////////////////////////////
	// Availability
	//////////////////////////////

	assign real_cgb_boot = (checksum == `GBL_CKSUM_ORIGINAL);

	// GBA mode needs the original ROM or the known custom build
	assign boot_gba_available = !custom_cgb || real_cgb_boot ||
		(checksum == `GBL_CKSUM_CUSTOM);

	// Fast boot only works with the known custom colour ROM, never with a custom DMG ROM
	assign fastboot_available =
		!((is_gbc && custom_cgb && checksum != `GBL_CKSUM_CUSTOM) ||
		(!is_gbc && custom_dmg));

endmodule

`default_nettype wire

// ==== design/cheat_assembler.sv ====
// Cheat record assembly from eight download words, with valid and clear strobes
`timescale 1ns/1ns
`default_nettype none
`include "gb_loader_consts.svh"

module cheat_assembler import gb_loader_pkg::*; (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  dl_kind_t              dl_kind,
	input  wire                   dl_start,
	input  wire                   wr_q,
	input  wire [`GBL_ADDR_W-1:0] addr_q,
	input  wire [`GBL_DATA_W-1:0] dout_q,
	output cheat_code_t           cheat_code,
	output logic                  cheat_valid,
	output logic                  cheat_clear
);

	logic cheat_write;

	assign cheat_write = wr_q && (dl_kind == DL_CHEAT);

	// Offset within the 16-byte record picks the half-field
	always_ff @(posedge clk_sys) begin
		if (cheat_write) begin
			case (addr_q[3:0])
				4'd0:  cheat_code.flags[15:0]    <= dout_q;
				4'd2:  cheat_code.flags[31:16]   <= dout_q;
				4'd4:  cheat_code.address[15:0]  <= dout_q;
				4'd6:  cheat_code.address[31:16] <= dout_q;
				4'd8:  cheat_code.compare[15:0]  <= dout_q;
				4'd10: cheat_code.compare[31:16] <= dout_q;
				4'd12: cheat_code.replace[15:0]  <= dout_q;
				4'd14: cheat_code.replace[31:16] <= dout_q;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Last word completes the record
			cheat_valid <= cheat_write && (addr_q[3:0] == 4'd14);
			// New cheat list, or a new cartridge, drops the old codes
			cheat_clear <= (cheat_write && addr_q == '0) ||
				(dl_start && dl_kind == DL_CART);
		end
	end

endmodule

`default_nettype wire

// ==== design/download_decode.sv ====
// Download kind decoder with start and end pulses and a one-cycle aligned stream
`timescale 1ns/1ns
`default_nettype none
`include "gb_loader_consts.svh"

module download_decode import gb_loader_pkg::*; (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    ioctl_download,
	input  wire                    ioctl_wr,
	input  wire [`GBL_FT_W-1:0]    filetype,
	input  wire [`GBL_ADDR_W-1:0]  ioctl_addr,
	input  wire [`GBL_DATA_W-1:0]  ioctl_dout,
	output dl_kind_t               dl_kind,
	output logic                   dl_start,
	output logic                   dl_end,
	output logic                   wr_q,
	output logic [`GBL_ADDR_W-1:0] addr_q,
	output logic [`GBL_DATA_W-1:0] dout_q
);

	dl_kind_t kind_next;
	dl_kind_t kind_prev;

	always_comb begin
		kind_next = DL_NONE;
		if (ioctl_download) begin
			if (filetype == `GBL_FT_CHEAT)
				kind_next = DL_CHEAT;
			else if (filetype[5:0] == `GBL_FT_CART || filetype == `GBL_FT_CART_RAW)
				kind_next = DL_CART;
			else if (filetype == `GBL_FT_CGB_BOOT)
				kind_next = DL_CGB_BOOT;
			else if (filetype == `GBL_FT_DMG_BOOT)
				kind_next = DL_DMG_BOOT;
			// Palettes and anything unknown are plain data here
			else
				kind_next = DL_OTHER;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_kind   <= DL_NONE;
			kind_prev <= DL_NONE;
			dl_start  <= 1'b0;
			dl_end    <= 1'b0;
			wr_q      <= 1'b0;
		end else begin
			dl_kind   <= kind_next;
			kind_prev <= dl_kind;
			// Edges of the registered kind, one cycle late
			dl_start  <= (dl_kind != DL_NONE) && (kind_prev == DL_NONE);
			dl_end    <= (dl_kind == DL_NONE) && (kind_prev != DL_NONE);
			wr_q      <= ioctl_wr;
		end
	end

	// Payload lines up with dl_kind
	always_ff @(posedge clk_sys) begin
		addr_q <= ioctl_addr;
		dout_q <= ioctl_dout;
	end

endmodule

`default_nettype wire

// ==== design/gb_loader_pkg.sv ====
// Download kind enum and cheat record struct shared by the loader modules
`default_nettype none

package gb_loader_pkg;

	//////////////////////////////
	// Download classification
	//////////////////////////////

	// None means no download is active
	typedef enum logic [2:0] {
		DL_NONE     = 3'd0,
		DL_CART     = 3'd1,
		DL_CGB_BOOT = 3'd2,
		DL_DMG_BOOT = 3'd3,
		DL_CHEAT    = 3'd4,
		DL_OTHER    = 3'd5
	} dl_kind_t;

	//////////////////////////////
	// Cheat record
	//////////////////////////////

	// Each field is sent by the host as a low word followed by a high word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

// ==== design/gb_loader_top.sv ====
// Loader top level joining download decode, boot checksum, cheats and backup RAM
`timescale 1ns/1ns
`default_nettype none
`include "gb_loader_consts.svh"

module gb_loader_top import gb_loader_pkg::*; (
	input  wire                   clk_sys,
	input  wire                   reset,
	// Host download stream
	input  wire                   ioctl_download,
	input  wire                   ioctl_wr,
	input  wire [`GBL_ADDR_W-1:0] ioctl_addr,
	input  wire [`GBL_DATA_W-1:0] ioctl_dout,
	input  wire [`GBL_FT_W-1:0]   filetype,
	input  wire                   is_gbc,
	// Backup RAM side
	input  wire                   img_mounted,
	input  wire                   img_readonly,
	input  wire                   cart_has_save,
	input  wire                   rtc_inuse,
	input  wire [`GBL_MASK_W-1:0] ram_mask,
	input  wire                   bk_load,
	input  wire                   bk_save,
	input  wire                   autosave,
	input  wire                   osd_open,
	input  wire                   cram_wr,
	input  wire                   sd_ack,
	input  wire                   sd_buff_wr,
	output wire                   fastboot_available,
	output wire                   boot_gba_available,
	output wire                   real_cgb_boot,
	output cheat_code_t           cheat_code,
	output wire                   cheat_valid,
	output wire                   cheat_clear,
	output wire [`GBL_LBA_W-1:0]  sd_lba,
	output wire                   sd_rd,
	output wire                   sd_wr,
	output wire                   bk_wr,
	output wire                   bk_busy,
	output wire                   bk_loading,
	output wire                   sav_pending,
	output wire                   sav_supported
);

	dl_kind_t               dl_kind;
	wire                    dl_start;
	wire                    dl_end;
	wire                    wr_q;
	wire [`GBL_ADDR_W-1:0]  addr_q;
	wire [`GBL_DATA_W-1:0]  dout_q;

	download_decode i_download_decode (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr), .filetype(filetype),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.dl_kind(dl_kind), .dl_start(dl_start), .dl_end(dl_end),
		.wr_q(wr_q), .addr_q(addr_q), .dout_q(dout_q)
	);

	boot_checksum i_boot_checksum (
		.clk_sys(clk_sys), .reset(reset), .is_gbc(is_gbc),
		.dl_kind(dl_kind), .dl_start(dl_start), .wr_q(wr_q), .dout_q(dout_q),
		.fastboot_available(fastboot_available),
		.boot_gba_available(boot_gba_available),
		.real_cgb_boot(real_cgb_boot)
	);

	cheat_assembler i_cheat_assembler (
		.clk_sys(clk_sys), .reset(reset),
		.dl_kind(dl_kind), .dl_start(dl_start),
		.wr_q(wr_q), .addr_q(addr_q), .dout_q(dout_q),
		.cheat_code(cheat_code), .cheat_valid(cheat_valid), .cheat_clear(cheat_clear)
	);

	backup_sequencer i_backup_sequencer (
		.clk_sys(clk_sys), .reset(reset),
		.dl_kind(dl_kind), .dl_start(dl_start), .dl_end(dl_end),
		.img_mounted(img_mounted), .img_readonly(img_readonly),
		.cart_has_save(cart_has_save), .rtc_inuse(rtc_inuse), .ram_mask(ram_mask),
		.bk_load(bk_load), .bk_save(bk_save), .autosave(autosave),
		.osd_open(osd_open), .cram_wr(cram_wr),
		.sd_ack(sd_ack), .sd_buff_wr(sd_buff_wr),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .bk_wr(bk_wr),
		.bk_busy(bk_busy), .bk_loading(bk_loading),
		.sav_pending(sav_pending), .sav_supported(sav_supported)
	);

endmodule

`default_nettype wire

// ==== gb_loader_top.f ====
+incdir+include
design/gb_loader_pkg.sv
design/download_decode.sv
design/boot_checksum.sv
design/cheat_assembler.sv
design/backup_sequencer.sv
design/gb_loader_top.sv
tb/gb_loader_assert.sv
tb/gb_loader_checker.sv
tb/gb_loader_tb.sv

// ==== include/gb_loader_consts.svh ====
// Loader widths, host file-type codes and colour boot ROM checksums
`ifndef GB_LOADER_CONSTS_SVH
`define GB_LOADER_CONSTS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

// Host download stream
`define GBL_DATA_W 16
`define GBL_ADDR_W 25
`define GBL_FT_W 8

// SD block interface and cartridge RAM size mask
`define GBL_LBA_W 32
`define GBL_MASK_W 8

// Running byte sum of the colour boot ROM
`define GBL_CKSUM_W 18

//////////////////////////////
// File-type codes
//////////////////////////////

// Cartridge images match on the low six bits, or use the raw code 80h
`define GBL_FT_CART 6'h01
`define GBL_FT_CART_RAW 8'h80
`define GBL_FT_PALETTE 8'h03
`define GBL_FT_CGB_BOOT 8'h04
`define GBL_FT_DMG_BOOT 8'h05
`define GBL_FT_CHEAT 8'hFF

// Known colour boot ROM sums
`define GBL_CKSUM_CUSTOM 18'h2CC8C
`define GBL_CKSUM_ORIGINAL 18'h2F3EA

`endif

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module gb_loader_tb \
	-f gb_loader_top.f -o gb_loader_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/gb_loader_sim > sim.log 2>&1
cat sim.log

grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "simulation did not finish"; exit 1; }
exit 0

// ==== tb/gb_loader_assert.sv ====
// SD request protocol assertions for the backup sequencer
`timescale 1ns/1ns
`default_nettype none
`include "gb_loader_consts.svh"

module gb_loader_assert (
	input wire                  clk_sys,
	input wire                  reset,
	input wire                  sd_rd,
	input wire                  sd_wr,
	input wire                  sd_ack,
	input wire                  bk_busy,
	input wire [`GBL_LBA_W-1:0] sd_lba
);

	// One direction at a time
	assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

	// Block number moves only inside a transfer
	assert property (@(posedge clk_sys) disable iff (reset) $changed(sd_lba) |-> bk_busy)
		else $error("sd_lba changed while idle");

	//////////////////////////////
	// Acknowledge handshake
	//////////////////////////////

	assert property (@(posedge clk_sys) disable iff (reset) $rose(sd_rd) |-> !sd_ack)
		else $error("sd_rd rose while sd_ack high");

	assert property (@(posedge clk_sys) disable iff (reset) $rose(sd_wr) |-> !sd_ack)
		else $error("sd_wr rose while sd_ack high");

endmodule

`default_nettype wire

// ==== tb/gb_loader_checker.sv ====
// Reference model and comparator for the loader DUT ports
`timescale 1ns/1ns
`default_nettype none
`include "gb_loader_consts.svh"

module gb_loader_checker import gb_loader_pkg::*; (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   ioctl_download,
	input  wire                   ioctl_wr,
	input  wire [`GBL_ADDR_W-1:0] ioctl_addr,
	input  wire [`GBL_DATA_W-1:0] ioctl_dout,
	input  wire [`GBL_FT_W-1:0]   filetype,
	input  wire                   is_gbc,
	input  wire                   img_mounted,
	input  wire                   img_readonly,
	input  wire                   cart_has_save,
	input  wire                   rtc_inuse,
	input  wire [`GBL_MASK_W-1:0] ram_mask,
	input  wire                   bk_load,
	input  wire                   bk_save,
	input  wire                   autosave,
	input  wire                   osd_open,
	input  wire                   cram_wr,
	input  wire                   sd_ack,
	input  wire                   sd_buff_wr,
	input  wire                   fastboot_available,
	input  wire                   boot_gba_available,
	input  wire                   real_cgb_boot,
	input  cheat_code_t           cheat_code,
	input  wire                   cheat_valid,
	input  wire                   cheat_clear,
	input  wire [`GBL_LBA_W-1:0]  sd_lba,
	input  wire                   sd_rd,
	input  wire                   sd_wr,
	input  wire                   bk_wr,
	input  wire                   bk_busy,
	input  wire                   bk_loading,
	input  wire                   sav_pending,
	input  wire                   sav_supported,
	input  wire                   final_check,
	output logic                  final_done,
	output int                    error_count
);

	logic [`GBL_CKSUM_W-1:0] sum_m;
	logic        cgb_m, dmg_m, ena_m, pend_m, load_m;
	logic        dl_q, load_q, save_q, osd_q, busy_q, req_q;
	logic        exp_real, exp_gba, exp_fast, exp_bk_wr, cart_ft;
	int          quiet, rst_cycles, next_lba, clr_exp, clr_seen;
	cheat_code_t rec_m;
	cheat_code_t exp_q [$];

	task automatic note_error(input string msg);
		$display("error at %0t: %s", $time, msg);
		error_count++;
	endtask

	initial begin
		error_count = 0;
		final_done  = 1'b0;
	end

	assign cart_ft = (filetype[5:0] == `GBL_FT_CART) || (filetype == `GBL_FT_CART_RAW);

	always @(posedge clk_sys) begin
		if (reset) begin
			{sum_m, cgb_m, dmg_m, ena_m, pend_m, load_m} = '0;
			{dl_q, load_q, save_q, osd_q, busy_q, req_q} = '0;
			{quiet, next_lba, clr_exp, clr_seen} = '0;
			rst_cycles++;
			// Registered outputs settle one cycle into reset
			if (rst_cycles > 2 && (cheat_valid || cheat_clear || sd_rd || sd_wr ||
				bk_busy || bk_loading || sav_pending))
				note_error("control output active during reset");
			if (rst_cycles > 2 && !(fastboot_available && boot_gba_available))
				note_error("availability flags low during reset");
		end else begin
			// Download start and the cart save image
			if (ioctl_download && !dl_q) begin
				if (filetype == `GBL_FT_CGB_BOOT) begin
					cgb_m = 1'b1;
					sum_m = '0;
				end
				if (filetype == `GBL_FT_DMG_BOOT)
					dmg_m = 1'b1;
				if (cart_ft) begin
					ena_m = 1'b0;
					clr_exp++;
				end
			end
			if (ioctl_download && cart_ft && img_mounted && !img_readonly)
				ena_m = 1'b1;
			if (ioctl_download && ioctl_wr && filetype == `GBL_FT_CGB_BOOT)
				sum_m = sum_m + ioctl_dout[15:8] + ioctl_dout[7:0];
			if (ioctl_download && ioctl_wr && filetype == `GBL_FT_CHEAT) begin
				case (ioctl_addr[3:0])
					4'd0:  rec_m.flags[15:0]    = ioctl_dout;
					4'd2:  rec_m.flags[31:16]   = ioctl_dout;
					4'd4:  rec_m.address[15:0]  = ioctl_dout;
					4'd6:  rec_m.address[31:16] = ioctl_dout;
					4'd8:  rec_m.compare[15:0]  = ioctl_dout;
					4'd10: rec_m.compare[31:16] = ioctl_dout;
					4'd12: rec_m.replace[15:0]  = ioctl_dout;
					4'd14: rec_m.replace[31:16] = ioctl_dout;
					default: ;
				endcase
				if (ioctl_addr[3:0] == 4'd14)
					exp_q.push_back(rec_m);
				if (ioctl_addr == '0)
					clr_exp++;
			end

			// Transfer direction and the pending save
			if (!ioctl_download && dl_q && cart_ft && cart_has_save && ena_m) begin
				load_m = 1'b1;
				pend_m = 1'b0;
			end
			if (bk_load && !load_q) begin
				load_m = 1'b1;
				pend_m = pend_m && !ena_m;
			end
			if ((bk_save && !save_q) || (osd_open && autosave && pend_m)) begin
				load_m = 1'b0;
				pend_m = pend_m && !ena_m;
			end
			if (cram_wr && !osd_open && cart_has_save && ena_m)
				pend_m = 1'b1;

			// Cheat strobes
			if (cheat_clear)
				clr_seen++;
			if (cheat_valid) begin
				if (exp_q.size() == 0)
					note_error("cheat_valid without a complete record");
				else if (cheat_code != exp_q[0])
					note_error($sformatf("cheat_code %h, expected %h", cheat_code, exp_q[0]));
				if (exp_q.size() != 0)
					void'(exp_q.pop_front());
			end

			// Block requests must step through the LBAs in order
			if ((sd_rd || sd_wr) && !req_q) begin
				if (sd_rd != load_m || sd_wr != !load_m)
					note_error($sformatf("request rd %b wr %b, load %b", sd_rd, sd_wr, load_m));
				if (sd_lba != next_lba)
					note_error($sformatf("sd_lba %0d, expected %0d", sd_lba, next_lba));
				next_lba++;
			end
			if (busy_q && !bk_busy && next_lba != int'(ram_mask) + int'(rtc_inuse) + 1)
				note_error($sformatf("transfer ended after %0d blocks", next_lba));
			if (!bk_busy)
				next_lba = 0;

			// Direction flag follows the model while busy
			if (bk_loading != (bk_busy && load_m))
				note_error($sformatf("bk_loading %b, expected %b", bk_loading,
					bk_busy && load_m));

			// Block in flight is the last one requested
			exp_bk_wr = sd_buff_wr && sd_ack && (next_lba - 1 <= int'(ram_mask));
			if (bk_wr != exp_bk_wr)
				note_error($sformatf("bk_wr %b at lba %0d, expected %b", bk_wr, sd_lba, exp_bk_wr));

			// Levels are compared once the inputs have been still for a while
			if (ioctl_download || cram_wr || bk_busy || bk_load || bk_save || osd_open != osd_q)
				quiet = 0;
			else if (quiet < 100)
				quiet++;
			exp_real = (sum_m == `GBL_CKSUM_ORIGINAL);
			exp_gba  = !cgb_m || exp_real || (sum_m == `GBL_CKSUM_CUSTOM);
			exp_fast = !((is_gbc && cgb_m && sum_m != `GBL_CKSUM_CUSTOM) || (!is_gbc && dmg_m));
			if (quiet >= 4) begin
				if ({real_cgb_boot, boot_gba_available, fastboot_available} !=
					{exp_real, exp_gba, exp_fast})
					note_error($sformatf("boot flags %b%b%b, expected %b%b%b, sum %h",
						real_cgb_boot, boot_gba_available, fastboot_available,
						exp_real, exp_gba, exp_fast, sum_m));
				if (sav_pending != pend_m)
					note_error($sformatf("sav_pending %b, expected %b", sav_pending, pend_m));
				if (sav_supported != (cart_has_save && ena_m))
					note_error($sformatf("sav_supported %b unexpected", sav_supported));
			end

			if (final_check && !final_done) begin
				if (exp_q.size() != 0)
					note_error($sformatf("%0d cheat records never strobed", exp_q.size()));
				if (clr_seen != clr_exp)
					note_error($sformatf("cheat_clear %0d pulses, expected %0d", clr_seen, clr_exp));
				final_done = 1'b1;
			end

			dl_q   = ioctl_download;
			load_q = bk_load;
			save_q = bk_save;
			osd_q  = osd_open;
			busy_q = bk_busy;
			req_q  = sd_rd || sd_wr;
		end
	end

endmodule

`default_nettype wire

// ==== include/gb_loader_tb_consts.svh ====
// Testbench timing limits for the loader testbench
`ifndef GB_LOADER_TB_CONSTS_SVH
`define GB_LOADER_TB_CONSTS_SVH

// Clock period in ns
`define TB_CLK_PERIOD 8

// Cycle limits for the waits in the testbench
`define TB_XFER_START_LIMIT 400
`define TB_XFER_END_LIMIT 8000
`define TB_FINAL_LIMIT 50

`endif

// ==== tb/gb_loader_tb.sv ====
// Loader testbench top with clock, reset, stimulus table, SD responder and closing line
`timescale 1ns/1ns
`default_nettype none
`include "gb_loader_consts.svh"
`include "gb_loader_tb_consts.svh"

module gb_loader_tb import gb_loader_pkg::*; ();

	localparam logic [2:0] OP_DL   = 3'd0;
	localparam logic [2:0] OP_LOAD = 3'd1;
	localparam logic [2:0] OP_CRAM = 3'd2;
	localparam logic [2:0] OP_OSD  = 3'd3;
	localparam logic [2:0] OP_GBC  = 3'd4;
	localparam int NSTEPS = 19;

	// Mount 0 leaves the image alone, 1 mounts writable, 2 mounts read-only
	typedef struct packed {
		logic [2:0]  op;
		logic [7:0]  ft;
		logic [1:0]  mount;
		logic [15:0] fill;
		logic [15:0] last;
		logic [9:0]  count;
		logic        level;
		logic [7:0]  mask;
		logic        rtc;
		logic        xfer;
	} row_t;

	logic                   clk_sys;
	logic                   reset;
	logic                   ioctl_download;
	logic                   ioctl_wr;
	logic [`GBL_ADDR_W-1:0] ioctl_addr;
	logic [`GBL_DATA_W-1:0] ioctl_dout;
	logic [`GBL_FT_W-1:0]   filetype;
	logic                   is_gbc;
	logic                   img_mounted;
	logic                   img_readonly;
	logic                   cart_has_save;
	logic                   rtc_inuse;
	logic [`GBL_MASK_W-1:0] ram_mask;
	logic                   bk_load;
	logic                   bk_save;
	logic                   autosave;
	logic                   osd_open;
	logic                   cram_wr;
	logic                   sd_ack;
	logic                   sd_buff_wr;
	wire                    fastboot_available;
	wire                    boot_gba_available;
	wire                    real_cgb_boot;
	cheat_code_t            cheat_code;
	wire                    cheat_valid;
	wire                    cheat_clear;
	wire [`GBL_LBA_W-1:0]   sd_lba;
	wire                    sd_rd;
	wire                    sd_wr;
	wire                    bk_wr;
	wire                    bk_busy;
	wire                    bk_loading;
	wire                    sav_pending;
	wire                    sav_supported;
	logic                   final_check;
	wire                    final_done;
	int                     error_count;

	int   seed = 32'h8f825465;
	bit   timeout_hit;
	row_t steps [NSTEPS];

	gb_loader_top i_gb_loader_top (.*);

	gb_loader_checker i_gb_loader_checker (.*);

	bind backup_sequencer gb_loader_assert i_gb_loader_assert (
		.clk_sys(clk_sys),
		.reset(reset),
		.sd_rd(sd_rd),
		.sd_wr(sd_wr),
		.sd_ack(sd_ack),
		.bk_busy(bk_busy),
		.sd_lba(sd_lba)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(`TB_CLK_PERIOD / 2) clk_sys = !clk_sys;
	end

	//////////////////////////////
	// SD responder
	//////////////////////////////

	initial begin : sd_responder
		int   delay;
		logic is_read;
		sd_ack     = 1'b0;
		sd_buff_wr = 1'b0;
		forever begin
			@(negedge clk_sys);
			if ((sd_rd || sd_wr) && !sd_ack) begin
				is_read = sd_rd;
				delay   = 1 + ({$random(seed)} % 6);
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b1;
				// Reads push two buffer words while the block is acknowledged
				repeat (2) begin
					@(negedge clk_sys);
					sd_buff_wr = is_read;
					@(negedge clk_sys);
					sd_buff_wr = 1'b0;
				end
				sd_ack = 1'b0;
			end
		end
	end

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic download(input row_t r);
		int          i;
		logic [15:0] word;
		@(negedge clk_sys);
		filetype       = r.ft;
		ioctl_download = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (i = 0; i < int'(r.count); i++) begin
			if (r.ft == `GBL_FT_CHEAT)
				word = 16'($random(seed));
			else
				word = (i == int'(r.count) - 1) ? r.last : r.fill;
			ioctl_wr   = 1'b1;
			ioctl_addr = `GBL_ADDR_W'(i * 2);
			ioctl_dout = word;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			@(negedge clk_sys);
			// The save image arrives halfway through the cart
			if (i == int'(r.count) / 2 && r.mount != 2'd0) begin
				img_mounted  = 1'b1;
				img_readonly = (r.mount == 2'd2);
				@(negedge clk_sys);
				img_mounted = 1'b0;
			end
		end
		repeat (2) @(negedge clk_sys);
		ioctl_download = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic wait_transfer();
		int n;
		n = 0;
		while (!bk_busy && n < `TB_XFER_START_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!bk_busy) begin
			$display("timeout: backup transfer never started at %0t", $time);
			timeout_hit = 1'b1;
		end else begin
			n = 0;
			while (bk_busy && n < `TB_XFER_END_LIMIT) begin
				@(negedge clk_sys);
				n++;
			end
			if (bk_busy) begin
				$display("timeout: backup transfer never finished at %0t", $time);
				timeout_hit = 1'b1;
			end
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int step;
		int n;
		// Original, custom and other colour boot ROMs, then DMG boot
		steps[0]  = '{OP_DL, 8'h04, 2'd0, 16'hFFFF, 16'h00E0, 10'd380, 1'b0, 8'd3, 1'b0, 1'b0};
		steps[1]  = '{OP_GBC, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b1, 8'd3, 1'b0, 1'b0};
		steps[2]  = '{OP_GBC, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b0, 8'd3, 1'b0, 1'b0};
		steps[3]  = '{OP_DL, 8'h04, 2'd0, 16'hFFFF, 16'hFF5B, 10'd360, 1'b0, 8'd3, 1'b0, 1'b0};
		steps[4]  = '{OP_GBC, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b1, 8'd3, 1'b0, 1'b0};
		steps[5]  = '{OP_GBC, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b0, 8'd3, 1'b0, 1'b0};
		steps[6]  = '{OP_DL, 8'h04, 2'd0, 16'h1234, 16'h0001, 10'd40, 1'b0, 8'd3, 1'b0, 1'b0};
		steps[7]  = '{OP_GBC, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b1, 8'd3, 1'b0, 1'b0};
		steps[8]  = '{OP_GBC, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b0, 8'd3, 1'b0, 1'b0};
		steps[9]  = '{OP_DL, 8'h05, 2'd0, 16'h00AA, 16'h0055, 10'd16, 1'b0, 8'd3, 1'b0, 1'b0};
		steps[10] = '{OP_GBC, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b1, 8'd3, 1'b0, 1'b0};
		// Two cheat records, then a cart with a writable save
		steps[11] = '{OP_DL, 8'hFF, 2'd0, 16'h0, 16'h0, 10'd16, 1'b0, 8'd3, 1'b0, 1'b0};
		steps[12] = '{OP_DL, 8'h01, 2'd1, 16'h00C3, 16'h0000, 10'd32, 1'b0, 8'd3, 1'b0, 1'b1};
		steps[13] = '{OP_LOAD, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b0, 8'd3, 1'b1, 1'b1};
		steps[14] = '{OP_CRAM, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b0, 8'd3, 1'b0, 1'b0};
		steps[15] = '{OP_OSD, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b1, 8'd3, 1'b0, 1'b1};
		steps[16] = '{OP_OSD, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b0, 8'd3, 1'b0, 1'b0};
		// Read-only image leaves the save unsupported
		steps[17] = '{OP_DL, 8'h80, 2'd2, 16'h0011, 16'h0022, 10'd8, 1'b0, 8'd1, 1'b0, 1'b0};
		steps[18] = '{OP_CRAM, 8'h00, 2'd0, 16'h0, 16'h0, 10'd0, 1'b0, 8'd1, 1'b0, 1'b0};

		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		filetype       = '0;
		is_gbc         = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		cart_has_save  = 1'b1;
		rtc_inuse      = 1'b0;
		ram_mask       = 8'd3;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		autosave       = 1'b1;
		osd_open       = 1'b0;
		cram_wr        = 1'b0;
		final_check    = 1'b0;
		timeout_hit    = 1'b0;

		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		repeat (4) @(negedge clk_sys);

		for (step = 0; step < NSTEPS && !timeout_hit; step++) begin
			ram_mask  = steps[step].mask;
			rtc_inuse = steps[step].rtc;
			case (steps[step].op)
				OP_DL: download(steps[step]);
				OP_LOAD: begin
					bk_load = 1'b1;
					@(negedge clk_sys);
					bk_load = 1'b0;
				end
				OP_CRAM: begin
					cram_wr = 1'b1;
					@(negedge clk_sys);
					cram_wr = 1'b0;
				end
				OP_OSD: osd_open = steps[step].level;
				default: is_gbc = steps[step].level;
			endcase
			if (steps[step].xfer)
				wait_transfer();
			repeat (8) @(negedge clk_sys);
		end

		if (!timeout_hit) begin
			final_check = 1'b1;
			n = 0;
			while (!final_done && n < `TB_FINAL_LIMIT) begin
				@(negedge clk_sys);
				n++;
			end
			if (!final_done) begin
				$display("timeout: checker never finished its closing checks");
				timeout_hit = 1'b1;
			end
		end

		$display("closing: %0d errors, %0d timeouts", error_count, int'(timeout_hit));
		if (error_count == 0 && !timeout_hit) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
